/* source/fb_pkg.sv */
`default_nettype none

package fb_pkg;

  // frame geometry
  localparam int h_res = 16;
  localparam int v_res = 12;
  localparam int fb_depth = h_res * v_res;

  // stored word is color over depth
  localparam int color_bits = 12;
  localparam int z_bits = 4;
  localparam int pixel_bits = color_bits + z_bits;

  typedef logic [$clog2(h_res)-1:0] col_t;
  typedef logic [$clog2(v_res)-1:0] row_t;
  typedef logic [$clog2(fb_depth)-1:0] fb_addr_t;
  typedef logic [pixel_bits-1:0] pixel_t;
  typedef logic bank_t;

  // gray coded so each step flips one bit
  typedef enum logic [1:0] {
    start_frame  = 2'b00,
    wait_req_low = 2'b01,
    wait_finish  = 2'b11,
    wait_swap    = 2'b10
  } swap_state_t;

  typedef struct packed {
    logic   cyc;
    logic   stb;
    logic   we;
    row_t   row;
    col_t   col;
    pixel_t wdata;
  } raster_wb_req_t;

  typedef struct packed {
    logic   ack;
    pixel_t rdata;
  } raster_wb_rsp_t;

  typedef struct packed {
    row_t row;
    col_t col;
  } disp_req_t;

  typedef struct packed {
    logic pools_empty;
    logic draw_start;
    logic draw_done;
    logic frame_req;
  } frame_evt_t;

  typedef struct packed {
    logic     en;
    fb_addr_t addr;
    pixel_t   data;
  } bank_wr_t;

  // row major linear address within one bank
  function automatic fb_addr_t lin_addr(row_t row, col_t col);
    return fb_addr_t'(row * h_res + col);
  endfunction

endpackage

`default_nettype wire

/* source/fb_pixel_ram.sv */
`default_nettype none

module fb_pixel_ram (
  input  logic             clk,
  input  fb_pkg::bank_wr_t wr,
  input  fb_pkg::fb_addr_t rd_addr,
  output fb_pkg::pixel_t   rd_data
);

  import fb_pkg::*;

  pixel_t mem [fb_depth];

  // write port, driven only for the drawing bank
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // registered read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // row and column from the ports must land inside the frame
  wr_addr_in_range: assert property (
    @(posedge clk) wr.en |-> (int'(wr.addr) < fb_depth)
  );

endmodule

`default_nettype wire

/* source/fb_swap_ctrl.sv */
`default_nettype none

module fb_swap_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  fb_pkg::frame_evt_t frame_evt,
  output logic               new_frame,
  output fb_pkg::bank_t      draw_bank
);

  import fb_pkg::*;

  swap_state_t state;
  logic        start_latch;
  logic        finish_latch;
  logic        start_clr;
  logic        finish_clr;

  // rasterizer has begun drawing the frame that was just offered
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_latch <= 1'b0;
    end else if (start_clr) begin
      start_latch <= 1'b0;
    end else if (new_frame && frame_evt.draw_start) begin
      start_latch <= 1'b1;
    end
  end

  // nothing left to draw and the rasterizer reports done
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      finish_latch <= 1'b0;
    end else if (finish_clr) begin
      finish_latch <= 1'b0;
    end else if (frame_evt.pools_empty && frame_evt.draw_done) begin
      finish_latch <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= start_frame;
      draw_bank  <= 1'b0;
      new_frame  <= 1'b0;
      start_clr  <= 1'b0;
      finish_clr <= 1'b0;
    end else begin
      // one-cycle strobes unless a state below raises them
      new_frame  <= 1'b0;
      start_clr  <= 1'b0;
      finish_clr <= 1'b0;

      case (state)
        // offer a fresh frame until drawing starts
        start_frame: begin
          new_frame  <= 1'b1;
          finish_clr <= 1'b1;
          if (start_latch) begin
            state <= wait_req_low;
          end
        end

        // a request still high from the last swap must not swap again
        wait_req_low: begin
          if (!frame_evt.frame_req) begin
            state <= wait_finish;
          end
        end

        wait_finish: begin
          if (finish_latch) begin
            start_clr <= 1'b1;
            state     <= wait_swap;
          end
        end

        // finished frame is held until the display asks for it
        wait_swap: begin
          if (frame_evt.frame_req) begin
            draw_bank <= ~draw_bank;
            state     <= start_frame;
          end
        end

        default: begin
          state <= start_frame;
        end
      endcase
    end
  end

  state_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
      state inside {start_frame, wait_req_low, wait_finish, wait_swap}
  );

endmodule

`default_nettype wire

/* source/fb_raster_port.sv */
`default_nettype none

module fb_raster_port (
  input  logic                   clk,
  input  logic                   rst_n,
  input  fb_pkg::raster_wb_req_t req,
  output fb_pkg::raster_wb_rsp_t rsp,
  input  fb_pkg::bank_t          draw_bank,
  output fb_pkg::bank_wr_t       wr0,
  output fb_pkg::bank_wr_t       wr1,
  output fb_pkg::fb_addr_t       rd_addr,
  input  fb_pkg::pixel_t         rd_data0,
  input  fb_pkg::pixel_t         rd_data1
);

  import fb_pkg::*;

  fb_addr_t addr;
  logic     ack_q;
  logic     req_new;
  bank_t    rd_bank_q;
  bank_wr_t wr_base;

  assign addr = lin_addr(req.row, req.col);

  // a request not yet acked, so back-to-back cycles get a gap
  assign req_new = req.cyc && req.stb && !ack_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_new;
    end
  end

  // write lands on the same edge that raises ack
  always_comb begin
    wr_base.en   = req_new && req.we;
    wr_base.addr = addr;
    wr_base.data = req.wdata;

    wr0    = wr_base;
    wr0.en = wr_base.en && (draw_bank == 1'b0);
    wr1    = wr_base;
    wr1.en = wr_base.en && (draw_bank == 1'b1);
  end

  // read address goes out every cycle, the top routes it to the drawing bank
  assign rd_addr = addr;

  // bank the read was issued to, lined up with the ram output
  always_ff @(posedge clk) begin
    rd_bank_q <= draw_bank;
  end

  assign rsp.ack   = ack_q;
  assign rsp.rdata = (rd_bank_q == 1'b1) ? rd_data1 : rd_data0;

  // ack only ever answers a request seen one cycle earlier
  ack_follows_req: assert property (
    @(posedge clk) disable iff (!rst_n)
      rsp.ack |-> $past(req.cyc && req.stb)
  );

endmodule

`default_nettype wire

/* source/fb_display_port.sv */
`default_nettype none

module fb_display_port (
  input  logic              clk,
  input  logic              rst_n,
  input  fb_pkg::disp_req_t req,
  input  fb_pkg::bank_t     draw_bank,
  output fb_pkg::fb_addr_t  rd_addr,
  input  fb_pkg::pixel_t    rd_data0,
  input  fb_pkg::pixel_t    rd_data1,
  output fb_pkg::pixel_t    pixel
);

  import fb_pkg::*;

  fb_addr_t addr_q;
  bank_t    vis_q;
  bank_t    vis_qq;

  // first stage, address register
  always_ff @(posedge clk) begin
    addr_q <= lin_addr(req.row, req.col);
  end

  // visible bank travels with the address, then with the ram read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vis_q  <= 1'b1;
      vis_qq <= 1'b1;
    end else begin
      vis_q  <= ~draw_bank;
      vis_qq <= vis_q;
    end
  end

  assign rd_addr = addr_q;

  // second stage output straight from the ram that was read
  assign pixel = (vis_qq == 1'b1) ? rd_data1 : rd_data0;

endmodule

`default_nettype wire

/* source/fb_top.sv */
`default_nettype none

module fb_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  fb_pkg::raster_wb_req_t raster_req,
  output fb_pkg::raster_wb_rsp_t raster_rsp,
  input  fb_pkg::disp_req_t      disp_req,
  output fb_pkg::pixel_t         disp_pixel,
  input  fb_pkg::frame_evt_t     frame_evt,
  output logic                   new_frame,
  output fb_pkg::bank_t          draw_bank
);

  import fb_pkg::*;

  bank_wr_t wr0;
  bank_wr_t wr1;
  fb_addr_t raster_rd_addr;
  fb_addr_t disp_rd_addr;
  fb_addr_t bank0_rd_addr;
  fb_addr_t bank1_rd_addr;
  pixel_t   rd_data0;
  pixel_t   rd_data1;

  fb_swap_ctrl swap_ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .frame_evt (frame_evt),
    .new_frame (new_frame),
    .draw_bank (draw_bank)
  );

  fb_raster_port raster_port_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (raster_req),
    .rsp       (raster_rsp),
    .draw_bank (draw_bank),
    .wr0       (wr0),
    .wr1       (wr1),
    .rd_addr   (raster_rd_addr),
    .rd_data0  (rd_data0),
    .rd_data1  (rd_data1)
  );

  fb_display_port display_port_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (disp_req),
    .draw_bank (draw_bank),
    .rd_addr   (disp_rd_addr),
    .rd_data0  (rd_data0),
    .rd_data1  (rd_data1),
    .pixel     (disp_pixel)
  );

  // drawing bank read port belongs to the rasterizer, the other to the display
  assign bank0_rd_addr = (draw_bank == 1'b0) ? raster_rd_addr : disp_rd_addr;
  assign bank1_rd_addr = (draw_bank == 1'b1) ? raster_rd_addr : disp_rd_addr;

  fb_pixel_ram bank0_i (
    .clk     (clk),
    .wr      (wr0),
    .rd_addr (bank0_rd_addr),
    .rd_data (rd_data0)
  );

  fb_pixel_ram bank1_i (
    .clk     (clk),
    .wr      (wr1),
    .rd_addr (bank1_rd_addr),
    .rd_data (rd_data1)
  );

endmodule

`default_nettype wire

/* verif/fb_tb.sv */
`default_nettype none

module fb_tb;

  import fb_pkg::*;

  typedef enum logic [2:0] {
    op_wr,
    op_rd,
    op_disp,
    op_evt,
    op_swap
  } op_t;

  // data and expected of each table row come from the shadow model
  typedef struct {
    string  name;
    op_t    op;
    row_t   row;
    col_t   col;
    pixel_t data;
    pixel_t expected;
  } step_t;

  logic           clk;
  logic           rst_n;
  raster_wb_req_t raster_req;
  raster_wb_rsp_t raster_rsp;
  disp_req_t      disp_req;
  pixel_t         disp_pixel;
  frame_evt_t     frame_evt;
  logic           new_frame;
  bank_t          draw_bank;

  step_t          steps[$];
  integer         seed;
  int             timeout_limit;
  int             cycle_count;

  // shadow of both banks and of the swap rules
  pixel_t         shadow [2][fb_depth];
  bank_t          shadow_bank;
  logic           shadow_finish;
  frame_evt_t     shadow_evt;

  fb_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .raster_req (raster_req),
    .raster_rsp (raster_rsp),
    .disp_req   (disp_req),
    .disp_pixel (disp_pixel),
    .frame_evt  (frame_evt),
    .new_frame  (new_frame),
    .draw_bank  (draw_bank)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    stop_with_failure($sformatf("Error: %s expected %0h actual %0h", name, expected, actual));
  endtask

  // appends a row and advances the shadow model by the same rules as the DUT
  task automatic add_step(input string name, input op_t op, input row_t row, input col_t col,
                          input frame_evt_t evt);
    step_t s;
    int    idx;
    idx        = int'(row) * h_res + int'(col);
    s.name     = name;
    s.op       = op;
    s.row      = row;
    s.col      = col;
    s.data     = '0;
    s.expected = '0;
    case (op)
      op_wr: begin
        s.data = pixel_t'($random(seed));
        shadow[shadow_bank][idx] = s.data;
      end
      op_rd: s.expected = shadow[shadow_bank][idx];
      // display always shows the bank that is not drawing
      op_disp: s.expected = shadow[~shadow_bank][idx];
      op_evt: begin
        s.data     = {12'b0, evt};
        shadow_evt = evt;
        if (evt.pools_empty && evt.draw_done) begin
          shadow_finish = 1'b1;
        end
      end
      op_swap: begin
        if (shadow_finish && shadow_evt.frame_req) begin
          shadow_bank   = ~shadow_bank;
          shadow_finish = 1'b0;
        end
        s.expected = pixel_t'(shadow_bank);
      end
      default: s.data = '0;
    endcase
    steps.push_back(s);
  endtask

  task automatic build_table();
    seed          = 46;
    shadow_bank   = 1'b0;
    shadow_finish = 1'b0;
    shadow_evt    = '0;
    // frame 1 drawn into bank 0
    add_step("f1_draw_start", op_evt, 4'd0, 4'd0, 4'b0100);
    add_step("f1_req_low", op_evt, 4'd0, 4'd0, 4'b0000);
    add_step("f1_write_a", op_wr, 4'd0, 4'd0, '0);
    add_step("f1_write_b", op_wr, 4'd3, 4'd5, '0);
    add_step("f1_write_c", op_wr, 4'd7, 4'd15, '0);
    add_step("f1_write_d", op_wr, 4'd11, 4'd9, '0);
    add_step("f1_read_a", op_rd, 4'd0, 4'd0, '0);
    add_step("f1_read_b", op_rd, 4'd3, 4'd5, '0);
    add_step("f1_read_c", op_rd, 4'd7, 4'd15, '0);
    add_step("f1_read_d", op_rd, 4'd11, 4'd9, '0);
    add_step("f1_done", op_evt, 4'd0, 4'd0, 4'b1010);
    add_step("f1_frame_req", op_evt, 4'd0, 4'd0, 4'b0001);
    add_step("f1_swap", op_swap, 4'd0, 4'd0, '0);
    // frame 1 is now on display while bank 1 is drawn
    add_step("f2_disp_a", op_disp, 4'd0, 4'd0, '0);
    add_step("f2_disp_b", op_disp, 4'd3, 4'd5, '0);
    add_step("f2_disp_c", op_disp, 4'd7, 4'd15, '0);
    add_step("f2_disp_d", op_disp, 4'd11, 4'd9, '0);
    add_step("f2_draw_start", op_evt, 4'd0, 4'd0, 4'b0100);
    add_step("f2_req_low", op_evt, 4'd0, 4'd0, 4'b0000);
    add_step("f2_write_a", op_wr, 4'd0, 4'd0, '0);
    add_step("f2_write_b", op_wr, 4'd3, 4'd5, '0);
    add_step("f2_write_c", op_wr, 4'd7, 4'd15, '0);
    add_step("f2_write_d", op_wr, 4'd11, 4'd9, '0);
    add_step("f2_read_a", op_rd, 4'd0, 4'd0, '0);
    add_step("f2_read_b", op_rd, 4'd3, 4'd5, '0);
    add_step("f2_read_c", op_rd, 4'd7, 4'd15, '0);
    add_step("f2_read_d", op_rd, 4'd11, 4'd9, '0);
    add_step("f2_disp_after_wr_a", op_disp, 4'd0, 4'd0, '0);
    add_step("f2_disp_after_wr_b", op_disp, 4'd3, 4'd5, '0);
    add_step("f2_disp_after_wr_c", op_disp, 4'd7, 4'd15, '0);
    add_step("f2_disp_after_wr_d", op_disp, 4'd11, 4'd9, '0);
    // done without empty pools must not allow a swap
    add_step("f2_done_only", op_evt, 4'd0, 4'd0, 4'b0010);
    add_step("f2_frame_req", op_evt, 4'd0, 4'd0, 4'b0001);
    add_step("f2_no_swap", op_swap, 4'd0, 4'd0, '0);
    add_step("f2_disp_held_a", op_disp, 4'd0, 4'd0, '0);
    add_step("f2_disp_held_d", op_disp, 4'd11, 4'd9, '0);
  endtask

  // one Wishbone classic cycle with ack expected one cycle after the request
  task automatic raster_access(input step_t s, input logic is_write);
    int waited;
    waited           = 0;
    raster_req.cyc   = 1'b1;
    raster_req.stb   = 1'b1;
    raster_req.we    = is_write;
    raster_req.row   = s.row;
    raster_req.col   = s.col;
    raster_req.wdata = is_write ? s.data : '0;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!raster_rsp.ack && waited < 4);
    assert (raster_rsp.ack)
      else stop_with_failure($sformatf("%s: raster port never acked the request", s.name));
    assert (waited == 1)
      else report_mismatch($sformatf("%s ack latency", s.name), 32'd1, 32'(waited));
    if (!is_write) begin
      assert (raster_rsp.rdata == s.expected)
        else report_mismatch(s.name, 32'(s.expected), 32'(raster_rsp.rdata));
    end
    raster_req.cyc = 1'b0;
    raster_req.stb = 1'b0;
    raster_req.we  = 1'b0;
    @(posedge clk);
    #1;
    assert (!raster_rsp.ack)
      else stop_with_failure($sformatf("%s: ack stayed high for a second cycle", s.name));
  endtask

  // address register then ram read put the word out two edges later
  task automatic display_read(input step_t s);
    disp_req.row = s.row;
    disp_req.col = s.col;
    @(posedge clk);
    #1;
    // next address right behind it keeps a shorter read from matching
    disp_req.col = s.col + 4'd1;
    @(posedge clk);
    #1;
    assert (disp_pixel == s.expected)
      else report_mismatch(s.name, 32'(s.expected), 32'(disp_pixel));
  endtask

  task automatic apply_event(input step_t s);
    frame_evt = s.data[3:0];
    @(posedge clk);
    #1;
  endtask

  task automatic swap_wait(input step_t s);
    int    waited;
    bank_t bank_before;
    waited      = 0;
    bank_before = draw_bank;
    while (draw_bank == bank_before && waited < 30) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (draw_bank == s.expected[0])
      else report_mismatch(s.name, 32'(s.expected[0]), 32'(draw_bank));
    if (draw_bank != bank_before) begin
      assert (!new_frame)
        else stop_with_failure($sformatf("%s: new_frame high on the swap cycle", s.name));
      @(posedge clk);
      #1;
      assert (new_frame)
        else stop_with_failure($sformatf("%s: new_frame did not follow the swap", s.name));
    end
  endtask

  initial begin
    #1;
    cycle_count = 0;
    while (cycle_count <= timeout_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    stop_with_failure($sformatf("timeout after %0d cycles, the tests never finished",
                                cycle_count));
  end

  initial begin
    rst_n      = 1'b0;
    raster_req = '0;
    disp_req   = '0;
    frame_evt  = '0;
    build_table();
    timeout_limit = 20 * steps.size() + 200;

    repeat (10) @(posedge clk);
    #1;
    assert (!new_frame)
      else stop_with_failure("new_frame was high while reset was asserted");
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    assert (new_frame)
      else report_mismatch("reset_new_frame", 32'd1, 32'(new_frame));
    assert (draw_bank == 1'b0)
      else report_mismatch("reset_draw_bank", 32'd0, 32'(draw_bank));

    foreach (steps[i]) begin
      case (steps[i].op)
        op_wr: raster_access(steps[i], 1'b1);
        op_rd: raster_access(steps[i], 1'b0);
        op_disp: display_read(steps[i]);
        op_evt: apply_event(steps[i]);
        op_swap: swap_wait(steps[i]);
        default: stop_with_failure("unknown operation in the test table");
      endcase
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
source/fb_pkg.sv
source/fb_pixel_ram.sv
source/fb_swap_ctrl.sv
source/fb_raster_port.sv
source/fb_display_port.sv
source/fb_top.sv
verif/fb_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run the simulation, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
log=sim.log
verilator --binary --assert --top-module fb_tb -f filelist.f --Mdir obj_dir -o fb_sim \
  > "$log" 2>&1 \
  && ./obj_dir/fb_sim >> "$log" 2>&1 \
  || echo "Done: errors found" >> "$log"
cat "$log"
grep -q "Done: errors found" "$log" && exit 1 || exit 0
